//--- periph_pkg.sv
/*
 * Peripheral bus definitions
 * Bus widths, address map, register indices and the request and
 * response structs shared by the bridge, decoder and peripherals.
 */
`default_nettype none

package periph_pkg;

   // **************************************************
   // Bus widths
   // **************************************************
   localparam int ADDR_W = 8;   // Byte address
   localparam int DATA_W = 32;

   // Address fields
   localparam int REGION_MSB = 7;
   localparam int REGION_LSB = 6;
   localparam int REG_MSB    = 5;
   localparam int REG_LSB    = 2;   // Word index inside a region

   // **************************************************
   // Address map
   // **************************************************
   localparam logic [1:0] REGION_GPIO0 = 2'd0;   // LEDs and switches
   localparam logic [1:0] REGION_GPIO1 = 2'd1;   // Buttons
   localparam logic [1:0] REGION_PWM   = 2'd2;   // RGB PWM, region 3 unmapped

   // GPIO registers
   localparam logic [3:0] GPIO_REG_IN  = 4'd0;
   localparam logic [3:0] GPIO_REG_OUT = 4'd1;
   localparam logic [3:0] GPIO_REG_OE  = 4'd2;

   // PWM registers, duties follow in order b0 g0 r0 b1 g1 r1
   localparam logic [3:0] PWM_REG_PERIOD = 4'd0;
   localparam logic [3:0] PWM_REG_DUTY0  = 4'd1;

   localparam int PWM_CNT_W = 16;
   localparam int PWM_CH    = 6;

   // **************************************************
   // Bus payloads
   // **************************************************
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic              we;
   } periph_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              err;
   } periph_rsp_t;

endpackage

`default_nettype wire

//--- bus_bridge.sv
/*
 * Host to bus bridge
 * Takes one valid/ready request at a time, runs it as a single
 * strobe/ack bus cycle and holds the response until the host takes it.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_bridge (
   input  wire                     clk,
   input  wire                     i_reset,
   input  periph_pkg::periph_req_t i_req,
   input  wire                     i_req_valid,
   output logic                    o_req_ready,
   output periph_pkg::periph_rsp_t o_rsp,
   output logic                    o_rsp_valid,
   input  wire                     i_rsp_ready,
   output periph_pkg::periph_req_t o_bus_req,
   output logic                    o_bus_stb,
   input  periph_pkg::periph_rsp_t i_bus_rsp,
   input  wire                     i_bus_ack
);
   import periph_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_BUS,
      S_RSP
   } state_t;

   state_t      state;
   logic        stb_q;
   logic        accept;
   logic        bus_done;
   periph_req_t req_q;
   periph_rsp_t rsp_q;

   assign accept   = i_req_valid & o_req_ready;
   assign bus_done = stb_q & i_bus_ack;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= S_IDLE;
         stb_q <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (accept) state <= S_BUS;
            S_BUS: begin
               if (!stb_q) begin
                  stb_q <= 1'b1;   // Strobe one cycle after accept
               end else if (bus_done) begin
                  stb_q <= 1'b0;
                  state <= S_RSP;
               end
            end
            S_RSP: if (i_rsp_ready) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   // Request and response holding
   always_ff @(posedge clk) begin
      if (accept) req_q <= i_req;
      if (bus_done) begin
         rsp_q.rdata <= req_q.we ? '0 : i_bus_rsp.rdata;   // Writes return zero
         rsp_q.err   <= i_bus_rsp.err;
      end
   end

   assign o_req_ready = (state == S_IDLE);
   assign o_rsp_valid = (state == S_RSP);
   assign o_rsp       = rsp_q;
   assign o_bus_req   = req_q;
   assign o_bus_stb   = stb_q;

   a_stb_until_ack: assert property (@(posedge clk) disable iff (i_reset)
      $fell(o_bus_stb) |-> $past(i_bus_ack))
      else $error("bus strobe dropped before ack");

endmodule

`default_nettype wire

//--- periph_decoder.sv
/*
 * Peripheral address decoder
 * Routes the bus strobe to one peripheral by address region and muxes
 * its ack and read data back. Unmapped space acks with an error.
 */
`timescale 1ns/10ps
`default_nettype none

module periph_decoder (
   input  periph_pkg::periph_req_t          i_bus_req,
   input  wire                              i_bus_stb,
   output periph_pkg::periph_rsp_t          o_bus_rsp,
   output logic                             o_bus_ack,
   input  wire                              clk,
   input  wire                              i_reset,
   output logic                             o_gpio0_stb,
   input  wire [periph_pkg::DATA_W-1:0]     i_gpio0_rdata,
   input  wire                              i_gpio0_ack,
   output logic                             o_gpio1_stb,
   input  wire [periph_pkg::DATA_W-1:0]     i_gpio1_rdata,
   input  wire                              i_gpio1_ack,
   output logic                             o_pwm_stb,
   input  wire [periph_pkg::DATA_W-1:0]     i_pwm_rdata,
   input  wire                              i_pwm_ack
);
   import periph_pkg::*;

   logic [REGION_MSB:REGION_LSB] region;
   logic                         unmapped_stb;
   logic                         unmapped_ack;

   assign region = i_bus_req.addr[REGION_MSB:REGION_LSB];

   always_comb begin
      o_gpio0_stb  = 1'b0;
      o_gpio1_stb  = 1'b0;
      o_pwm_stb    = 1'b0;
      unmapped_stb = 1'b0;
      o_bus_ack    = 1'b0;
      o_bus_rsp    = '0;
      case (region)
         REGION_GPIO0: begin
            o_gpio0_stb     = i_bus_stb;
            o_bus_ack       = i_gpio0_ack;
            o_bus_rsp.rdata = i_gpio0_rdata;
         end
         REGION_GPIO1: begin
            o_gpio1_stb     = i_bus_stb;
            o_bus_ack       = i_gpio1_ack;
            o_bus_rsp.rdata = i_gpio1_rdata;
         end
         REGION_PWM: begin
            o_pwm_stb       = i_bus_stb;
            o_bus_ack       = i_pwm_ack;
            o_bus_rsp.rdata = i_pwm_rdata;
         end
         default: begin   // Nothing here, error with zero data
            unmapped_stb  = i_bus_stb;
            o_bus_ack     = unmapped_ack;
            o_bus_rsp.err = unmapped_ack;
         end
      endcase
   end

   // Same ack timing as a real peripheral
   always_ff @(posedge clk) begin
      if (i_reset) unmapped_ack <= 1'b0;
      else         unmapped_ack <= unmapped_stb & ~unmapped_ack;
   end

   a_one_ack: assert property (@(posedge clk) disable iff (i_reset)
      $onehot0({i_gpio0_ack, i_gpio1_ack, i_pwm_ack, unmapped_ack}))
      else $error("more than one peripheral acked");

endmodule

`default_nettype wire

//--- gpio_block.sv
/*
 * GPIO register block
 * Output and output-enable registers plus a synchronized input
 * register, WIDTH pads wide, zero-extended onto the data bus.
 */
`timescale 1ns/10ps
`default_nettype none

module gpio_block #(
   parameter int WIDTH = 32
) (
   input  wire                          clk,
   input  wire                          i_reset,
   input  periph_pkg::periph_req_t      i_bus_req,
   input  wire                          i_stb,
   output logic [periph_pkg::DATA_W-1:0] o_rdata,
   output logic                         o_ack,
   input  wire  [WIDTH-1:0]             i_gpio_in,
   output logic [WIDTH-1:0]             o_gpio_out,
   output logic [WIDTH-1:0]             o_gpio_oe
);
   import periph_pkg::*;

   logic [REG_MSB:REG_LSB] idx;
   logic                   wr_en;
   logic [WIDTH-1:0]       out_q;
   logic [WIDTH-1:0]       oe_q;
   logic [WIDTH-1:0]       sync_q;
   logic [WIDTH-1:0]       in_q;

   assign idx   = i_bus_req.addr[REG_MSB:REG_LSB];
   assign wr_en = i_stb & ~o_ack & i_bus_req.we;   // Lands on the ack edge

   // **************************************************
   // Pad input synchronizer
   // **************************************************
   always_ff @(posedge clk) begin
      sync_q <= i_gpio_in;
      in_q   <= sync_q;
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ack <= 1'b0;
         out_q <= '0;
         oe_q  <= '0;
      end else begin
         o_ack <= i_stb & ~o_ack;
         if (wr_en) begin
            case (idx)
               GPIO_REG_OUT: out_q <= i_bus_req.wdata[WIDTH-1:0];
               GPIO_REG_OE:  oe_q  <= i_bus_req.wdata[WIDTH-1:0];
               default: ;   // Input and unused slots are read only
            endcase
         end
      end
   end

   // Readback, upper bits stay zero
   always_comb begin
      o_rdata = '0;
      case (idx)
         GPIO_REG_IN:  o_rdata[WIDTH-1:0] = in_q;
         GPIO_REG_OUT: o_rdata[WIDTH-1:0] = out_q;
         GPIO_REG_OE:  o_rdata[WIDTH-1:0] = oe_q;
         default:      o_rdata = '0;
      endcase
   end

   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;

endmodule

`default_nettype wire

//--- rgb_pwm.sv
/*
 * RGB PWM controller
 * One free-running period counter shared by six duty channels,
 * driving the blue, green and red pins of two RGB LEDs.
 */
`timescale 1ns/10ps
`default_nettype none

module rgb_pwm (
   input  wire                           clk,
   input  wire                           i_reset,
   input  periph_pkg::periph_req_t       i_bus_req,
   input  wire                           i_stb,
   output logic [periph_pkg::DATA_W-1:0] o_rdata,
   output logic                          o_ack,
   output logic [periph_pkg::PWM_CH-1:0] o_rgb
);
   import periph_pkg::*;

   logic [REG_MSB:REG_LSB] idx;
   logic                   wr_en;
   logic [PWM_CNT_W-1:0]   period_q;
   logic [PWM_CNT_W-1:0]   cnt_q;
   logic [PWM_CNT_W-1:0]   duty_q [PWM_CH];

   assign idx   = i_bus_req.addr[REG_MSB:REG_LSB];
   assign wr_en = i_stb & ~o_ack & i_bus_req.we;

   // **************************************************
   // Register writes
   // **************************************************
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ack    <= 1'b0;
         period_q <= '0;
         for (int i = 0; i < PWM_CH; i++) begin
            duty_q[i] <= '0;
         end
      end else begin
         o_ack <= i_stb & ~o_ack;
         if (wr_en) begin
            if (idx == PWM_REG_PERIOD) period_q <= i_bus_req.wdata[PWM_CNT_W-1:0];
            for (int i = 0; i < PWM_CH; i++) begin
               if (idx == PWM_REG_DUTY0 + 4'(i)) duty_q[i] <= i_bus_req.wdata[PWM_CNT_W-1:0];
            end
         end
      end
   end

   // Period counter
   always_ff @(posedge clk) begin
      if (i_reset) begin
         cnt_q <= '0;
      end else if (wr_en && idx == PWM_REG_PERIOD) begin
         cnt_q <= '0;   // Restart so a shorter period never overshoots
      end else if (cnt_q >= period_q) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   always_comb begin
      for (int i = 0; i < PWM_CH; i++) begin
         o_rgb[i] = (cnt_q < duty_q[i]);
      end
   end

   // Readback of the low counter-width bits
   always_comb begin
      o_rdata = '0;
      if (idx == PWM_REG_PERIOD) o_rdata[PWM_CNT_W-1:0] = period_q;
      for (int i = 0; i < PWM_CH; i++) begin
         if (idx == PWM_REG_DUTY0 + 4'(i)) o_rdata[PWM_CNT_W-1:0] = duty_q[i];
      end
   end

   a_cnt_in_period: assert property (@(posedge clk) disable iff (i_reset)
      cnt_q <= period_q)
      else $error("PWM counter past period");

endmodule

`default_nettype wire

//--- periph_top.sv
/*
 * Peripheral subsystem top level
 * Host bridge, address decoder, LED/switch GPIO, button GPIO
 * and the RGB PWM controller.
 */
`timescale 1ns/10ps
`default_nettype none

module periph_top #(
   parameter int GPIO0_WIDTH = 32,
   parameter int GPIO1_WIDTH = 4
) (
   input  wire                           clk,
   input  wire                           i_reset,
   input  periph_pkg::periph_req_t       i_req,
   input  wire                           i_req_valid,
   output logic                          o_req_ready,
   output periph_pkg::periph_rsp_t       o_rsp,
   output logic                          o_rsp_valid,
   input  wire                           i_rsp_ready,
   input  wire  [GPIO0_WIDTH-1:0]        i_gpio0_in,
   output logic [GPIO0_WIDTH-1:0]        o_gpio0_out,
   output logic [GPIO0_WIDTH-1:0]        o_gpio0_oe,
   input  wire  [GPIO1_WIDTH-1:0]        i_gpio1_in,
   output logic [GPIO1_WIDTH-1:0]        o_gpio1_out,
   output logic [GPIO1_WIDTH-1:0]        o_gpio1_oe,
   output logic [periph_pkg::PWM_CH-1:0] o_rgb
);
   import periph_pkg::*;

   periph_req_t       bus_req;
   periph_rsp_t       bus_rsp;
   logic              bus_stb;
   logic              bus_ack;
   logic              gpio0_stb;
   logic              gpio0_ack;
   logic              gpio1_stb;
   logic              gpio1_ack;
   logic              pwm_stb;
   logic              pwm_ack;
   logic [DATA_W-1:0] gpio0_rdata;
   logic [DATA_W-1:0] gpio1_rdata;
   logic [DATA_W-1:0] pwm_rdata;

   bus_bridge u_bridge (
      .clk(clk), .i_reset(i_reset),
      .i_req(i_req), .i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
      .o_rsp(o_rsp), .o_rsp_valid(o_rsp_valid), .i_rsp_ready(i_rsp_ready),
      .o_bus_req(bus_req), .o_bus_stb(bus_stb),
      .i_bus_rsp(bus_rsp), .i_bus_ack(bus_ack));

   periph_decoder u_decoder (
      .i_bus_req(bus_req), .i_bus_stb(bus_stb),
      .o_bus_rsp(bus_rsp), .o_bus_ack(bus_ack),
      .clk(clk), .i_reset(i_reset),
      .o_gpio0_stb(gpio0_stb), .i_gpio0_rdata(gpio0_rdata), .i_gpio0_ack(gpio0_ack),
      .o_gpio1_stb(gpio1_stb), .i_gpio1_rdata(gpio1_rdata), .i_gpio1_ack(gpio1_ack),
      .o_pwm_stb(pwm_stb), .i_pwm_rdata(pwm_rdata), .i_pwm_ack(pwm_ack));

   // LEDs and switches
   gpio_block #(.WIDTH(GPIO0_WIDTH)) u_gpio0 (
      .clk(clk), .i_reset(i_reset),
      .i_bus_req(bus_req), .i_stb(gpio0_stb),
      .o_rdata(gpio0_rdata), .o_ack(gpio0_ack),
      .i_gpio_in(i_gpio0_in), .o_gpio_out(o_gpio0_out), .o_gpio_oe(o_gpio0_oe));

   // Buttons
   gpio_block #(.WIDTH(GPIO1_WIDTH)) u_gpio1 (
      .clk(clk), .i_reset(i_reset),
      .i_bus_req(bus_req), .i_stb(gpio1_stb),
      .o_rdata(gpio1_rdata), .o_ack(gpio1_ack),
      .i_gpio_in(i_gpio1_in), .o_gpio_out(o_gpio1_out), .o_gpio_oe(o_gpio1_oe));

   rgb_pwm u_pwm (
      .clk(clk), .i_reset(i_reset),
      .i_bus_req(bus_req), .i_stb(pwm_stb),
      .o_rdata(pwm_rdata), .o_ack(pwm_ack),
      .o_rgb(o_rgb));

endmodule

`default_nettype wire

//--- tb_periph_model.svh
/*
 * Register model for the peripheral testbench
 * Expected GPIO and PWM register contents, the pad values last driven,
 * and the read and write rules of the address map.
 */
`ifndef TB_PERIPH_MODEL_SVH
`define TB_PERIPH_MODEL_SVH

logic [DATA_W-1:0]    model_out0;
logic [DATA_W-1:0]    model_oe0;
logic [DATA_W-1:0]    model_out1;
logic [DATA_W-1:0]    model_oe1;
logic [DATA_W-1:0]    model_in0;   // Raw random pad values
logic [DATA_W-1:0]    model_in1;
logic [PWM_CNT_W-1:0] model_pwm [7];   // Period, then six duties

function automatic logic [DATA_W-1:0] width_mask(input int w);
   if (w >= DATA_W) return '1;
   else return (32'd1 << w) - 32'd1;
endfunction

function automatic void model_reset();
   model_out0 = '0;
   model_oe0  = '0;
   model_out1 = '0;
   model_oe1  = '0;
   model_in0  = '0;
   model_in1  = '0;
   for (int i = 0; i < 7; i++) model_pwm[i] = '0;
endfunction

function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] data);
   logic [3:0] idx;
   idx = addr[REG_MSB:REG_LSB];
   case (addr[REGION_MSB:REGION_LSB])
      REGION_GPIO0: begin
         if (idx == GPIO_REG_OUT) model_out0 = data & width_mask(G0_W);
         if (idx == GPIO_REG_OE)  model_oe0  = data & width_mask(G0_W);
      end
      REGION_GPIO1: begin
         if (idx == GPIO_REG_OUT) model_out1 = data & width_mask(G1_W);
         if (idx == GPIO_REG_OE)  model_oe1  = data & width_mask(G1_W);
      end
      REGION_PWM: if (idx <= 4'd6) model_pwm[idx[2:0]] = data[PWM_CNT_W-1:0];
      default: ;   // Unmapped, nothing stored
   endcase
endfunction

function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
   logic [3:0]        idx;
   logic [DATA_W-1:0] val;
   idx = addr[REG_MSB:REG_LSB];
   val = '0;
   case (addr[REGION_MSB:REGION_LSB])
      REGION_GPIO0: begin
         if (idx == GPIO_REG_IN)  val = model_in0 & width_mask(G0_W);
         if (idx == GPIO_REG_OUT) val = model_out0;
         if (idx == GPIO_REG_OE)  val = model_oe0;
      end
      REGION_GPIO1: begin
         if (idx == GPIO_REG_IN)  val = model_in1 & width_mask(G1_W);
         if (idx == GPIO_REG_OUT) val = model_out1;
         if (idx == GPIO_REG_OE)  val = model_oe1;
      end
      REGION_PWM: if (idx <= 4'd6) val = DATA_W'(model_pwm[idx[2:0]]);
      default: val = '0;
   endcase
   return val;
endfunction

`endif

//--- tb_periph_top.sv
/*
 * Testbench for the peripheral subsystem
 * Random register traffic on the host channel, checked against a
 * register model: reset state, GPIO registers and pads, unmapped
 * space, PWM duty counts and response back-pressure.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_periph_top;
   import periph_pkg::*;

   localparam int G0_W    = 32;
   localparam int G1_W    = 4;
   localparam int TIMEOUT = 50;   // Cycles per wait

   logic              clk;
   logic              i_reset;
   periph_req_t       i_req;
   logic              i_req_valid;
   logic              o_req_ready;
   periph_rsp_t       o_rsp;
   logic              o_rsp_valid;
   logic              i_rsp_ready;
   logic [G0_W-1:0]   i_gpio0_in;
   logic [G0_W-1:0]   o_gpio0_out;
   logic [G0_W-1:0]   o_gpio0_oe;
   logic [G1_W-1:0]   i_gpio1_in;
   logic [G1_W-1:0]   o_gpio1_out;
   logic [G1_W-1:0]   o_gpio1_oe;
   logic [PWM_CH-1:0] o_rgb;

   integer seed;
   int     errors;
   int     checks;
   string  test_name;

   `include "tb_periph_model.svh"

   periph_top #(.GPIO0_WIDTH(G0_W), .GPIO1_WIDTH(G1_W)) DUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_value(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, got);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1) else begin
         errors++;
         $display("Error in %s: %s", test_name, what);
      end
   endtask

   task automatic check_pins();
      check_value("gpio0 out pins", model_out0, DATA_W'(o_gpio0_out));
      check_value("gpio0 oe pins", model_oe0, DATA_W'(o_gpio0_oe));
      check_value("gpio1 out pins", model_out1, DATA_W'(o_gpio1_out));
      check_value("gpio1 oe pins", model_oe1, DATA_W'(o_gpio1_oe));
   endtask

   function automatic logic [ADDR_W-1:0] rand_addr(input logic [1:0] region);
      return {region, 4'($random(seed)), 2'b00};
   endfunction

   // **************************************************
   // One host request, response held back for hold cycles
   // **************************************************
   task automatic run_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic we, input int hold);
      periph_req_t       r;
      periph_rsp_t       held;
      logic [DATA_W-1:0] exp_rdata;
      logic              exp_err;
      int                cnt;
      r.addr    = addr;
      r.wdata   = wdata;
      r.we      = we;
      exp_err   = (addr[REGION_MSB:REGION_LSB] == 2'd3);
      exp_rdata = (we || exp_err) ? '0 : expected_read(addr);
      @(posedge clk);
      i_req       <= r;
      i_req_valid <= 1'b1;
      i_rsp_ready <= (hold == 0);
      cnt = 0;
      @(negedge clk);
      while (!o_req_ready && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (!o_req_ready) begin
         check_true(1'b0, "request was never accepted");
         @(posedge clk);
         i_req_valid <= 1'b0;
      end else begin
         @(posedge clk);   // Accept edge
         i_req_valid <= 1'b0;
         cnt = 0;
         @(negedge clk);
         while (!o_rsp_valid && cnt < TIMEOUT) begin
            check_true(!o_req_ready, "ready went high before the response was taken");
            @(negedge clk);
            cnt++;
         end
         if (!o_rsp_valid) begin
            check_true(1'b0, "no response arrived within the timeout");
         end else begin
            check_value("response latency", 32'd3, cnt);
            check_value("read data", exp_rdata, o_rsp.rdata);
            check_value("error flag", 32'(exp_err), 32'(o_rsp.err));
            held = o_rsp;
            for (int n = 0; n < hold; n++) begin
               @(negedge clk);
               check_true(o_rsp_valid && !o_req_ready, "handshake moved while stalled");
               check_true(o_rsp === held, "response changed while stalled");
            end
            @(posedge clk);
            if (hold > 0) begin
               i_rsp_ready <= 1'b1;
               @(posedge clk);   // Response taken here
            end
            if (we) model_write(addr, wdata);
         end
      end
   endtask

   task automatic pwm_round();
      logic [PWM_CNT_W-1:0] period;
      int                   high_cnt [PWM_CH];
      int                   exp_cnt;
      for (int c = 0; c < PWM_CH; c++) begin
         run_access({REGION_PWM, PWM_REG_DUTY0 + 4'(c), 2'b00},
                    {16'($random(seed)), 16'($random(seed) & 32'h3f)}, 1'b1, 0);
      end
      run_access({REGION_PWM, PWM_REG_PERIOD, 2'b00},
                 {16'($random(seed)), 16'($random(seed) & 32'h3f)}, 1'b1, 0);
      for (int i = 0; i < 7; i++) begin
         run_access({REGION_PWM, 4'(i), 2'b00}, '0, 1'b0, 0);
      end
      period = model_pwm[0];
      for (int c = 0; c < PWM_CH; c++) high_cnt[c] = 0;
      for (int n = 0; n <= int'(period); n++) begin
         @(negedge clk);
         for (int c = 0; c < PWM_CH; c++) begin
            if (o_rgb[c]) high_cnt[c]++;
         end
      end
      for (int c = 0; c < PWM_CH; c++) begin
         exp_cnt = (model_pwm[c+1] <= period) ? int'(model_pwm[c+1]) : int'(period) + 1;
         check_value("high cycles per period", exp_cnt, high_cnt[c]);
      end
   endtask

   initial begin
      seed        = 32'hd28a_0a94;
      errors      = 0;
      checks      = 0;
      test_name   = "reset";
      i_reset     = 1'b1;
      i_req       = '0;
      i_req_valid = 1'b0;
      i_rsp_ready = 1'b1;
      i_gpio0_in  = '0;
      i_gpio1_in  = '0;
      model_reset();
      repeat (10) @(posedge clk);
      i_reset <= 1'b0;

      @(negedge clk);
      check_true(o_req_ready, "request ready is low after reset");
      check_true(!o_rsp_valid, "response valid is high after reset");
      check_value("rgb outputs", '0, DATA_W'(o_rgb));
      check_pins();

      test_name = "gpio_regs";
      repeat (60) begin
         run_access(rand_addr({1'b0, 1'($random(seed))}), $random(seed), 1'($random(seed)), 0);
      end
      check_pins();

      test_name = "gpio_input";
      repeat (8) begin
         model_in0 = $random(seed);
         model_in1 = $random(seed);
         @(posedge clk);
         i_gpio0_in <= model_in0[G0_W-1:0];
         i_gpio1_in <= model_in1[G1_W-1:0];
         repeat (4) @(posedge clk);   // Through the synchronizer
         run_access({REGION_GPIO0, GPIO_REG_IN, 2'b00}, '0, 1'b0, 0);
         run_access({REGION_GPIO1, GPIO_REG_IN, 2'b00}, '0, 1'b0, 0);
      end

      test_name = "pwm";
      repeat (4) pwm_round();

      test_name = "unmapped";
      repeat (12) run_access(rand_addr(2'd3), $random(seed), 1'($random(seed)), 0);
      check_pins();
      for (int i = 0; i < 7; i++) run_access({REGION_PWM, 4'(i), 2'b00}, '0, 1'b0, 0);

      test_name = "back_pressure";
      repeat (16) begin
         run_access(rand_addr(2'($random(seed))), $random(seed), 1'($random(seed)),
                    1 + ($random(seed) & 7));
      end
      check_pins();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
periph_pkg.sv
bus_bridge.sv
periph_decoder.sv
gpio_block.sv
rgb_pwm.sv
periph_top.sv
tb_periph_top.sv

//--- Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES = periph_pkg.sv bus_bridge.sv periph_decoder.sv gpio_block.sv \
          rgb_pwm.sv periph_top.sv tb_periph_top.sv tb_periph_model.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
